//--- hw/pix_pkg.sv
package pix_pkg;

	// stream and statistics widths.
	localparam int pix_w  = 16;
	localparam int luma_w = 8;
	localparam int stat_w = 24;

	// wishbone word addresses.
	localparam logic [1:0] reg_ctrl   = 2'd0;
	localparam logic [1:0] reg_thresh = 2'd1;
	localparam logic [1:0] reg_hits   = 2'd2;
	localparam logic [1:0] reg_frames = 2'd3;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef struct packed {
		logic [7:0] y;	// luma sits in the high byte.
		logic [7:0] c;
	} yc_t;

	// the same 16-bit word seen in either pixel format.
	typedef union packed {
		rgb565_t rgb;
		yc_t     yc;
	} pixel_word_t;

endpackage

//--- hw/axis_relay.sv
module axis_relay #(
	parameter int c_pixel_width = 8,
	parameter int c_passthrough = 0
) (
	input  logic                     clk,
	input  logic                     resetn,

	input  logic                     s_axis_tvalid,
	input  logic [c_pixel_width-1:0] s_axis_tdata,
	input  logic                     s_axis_tuser,
	input  logic                     s_axis_tlast,
	output logic                     s_axis_tready,

	output logic                     m_axis_tvalid,
	output logic [c_pixel_width-1:0] m_axis_tdata,
	output logic                     m_axis_tuser,
	output logic                     m_axis_tlast,
	input  logic                     m_axis_tready
);

	if (c_passthrough != 0) begin : g_wire
		assign m_axis_tvalid = s_axis_tvalid;
		assign m_axis_tdata  = s_axis_tdata;
		assign m_axis_tuser  = s_axis_tuser;
		assign m_axis_tlast  = s_axis_tlast;
		assign s_axis_tready = m_axis_tready;
	end else begin : g_skid
		logic [1:0]                    vld_q;	// entry 0 drives the output.
		logic [1:0][c_pixel_width-1:0] data_q;
		logic [1:0]                    user_q;
		logic [1:0]                    last_q;
		logic                          ready_q;
		logic                          take;
		logic                          drain;
		logic                          park;

		assign take  = s_axis_tvalid && ready_q;
		assign drain = !vld_q[0] || m_axis_tready;	// entry 0 may be refilled.
		assign park  = take && (vld_q[1] || !drain);

		assign m_axis_tvalid = vld_q[0];
		assign m_axis_tdata  = data_q[0];
		assign m_axis_tuser  = user_q[0];
		assign m_axis_tlast  = last_q[0];
		assign s_axis_tready = ready_q;

		always_ff @(posedge clk) begin
			if (!resetn) begin
				vld_q <= 2'b00;
			end else begin
				if (park)
					vld_q[1] <= 1'b1;
				else if (take || drain)
					vld_q[1] <= 1'b0;
				if (drain)
					vld_q[0] <= vld_q[1] || take;
			end
		end

		always_ff @(posedge clk) begin
			if (park) begin
				data_q[1] <= s_axis_tdata;
				user_q[1] <= s_axis_tuser;
				last_q[1] <= s_axis_tlast;
			end
			if (drain) begin
				if (vld_q[1]) begin
					data_q[0] <= data_q[1];
					user_q[0] <= user_q[1];
					last_q[0] <= last_q[1];
				end else begin
					data_q[0] <= s_axis_tdata;
					user_q[0] <= s_axis_tuser;
					last_q[0] <= s_axis_tlast;
				end
			end
		end

		// ready is registered, so it looks one beat ahead of the stall.
		always_ff @(posedge clk) begin
			if (!resetn) begin
				ready_q <= 1'b0;
			end else begin
				case (vld_q)
					2'b00, 2'b10: ready_q <= 1'b1;
					2'b01:        ready_q <= !ready_q || m_axis_tready;
					default:      ready_q <= !ready_q && m_axis_tready;
				endcase
			end
		end
	end

endmodule

//--- hw/pixel_decode.sv
module pixel_decode (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      fmt_yc,

	input  logic                      s_valid,
	input  logic [pix_pkg::pix_w-1:0] s_data,
	input  logic                      s_user,
	input  logic                      s_last,
	output logic                      s_ready,

	output logic                      m_valid,
	output logic [pix_pkg::luma_w-1:0] m_luma,
	output logic                      m_user,
	output logic                      m_last,
	input  logic                      m_ready
);

	pix_pkg::pixel_word_t word;
	logic [7:0]           r8;
	logic [7:0]           g8;
	logic [7:0]           b8;
	logic [10:0]          weighted;
	logic [pix_pkg::luma_w-1:0] luma;

	assign word = s_data;

	// widen each field by repeating its top bits into the low bits.
	assign r8 = {word.rgb.r, word.rgb.r[4:2]};
	assign g8 = {word.rgb.g, word.rgb.g[5:4]};
	assign b8 = {word.rgb.b, word.rgb.b[4:2]};

	assign weighted = 11'(2 * r8) + 11'(5 * g8) + 11'(b8);	// at most 2040.
	assign luma     = fmt_yc ? word.yc.y : weighted[10:3];

	assign s_ready = !m_valid || m_ready;

	always_ff @(posedge clk) begin
		if (!resetn)
			m_valid <= 1'b0;
		else if (s_ready)
			m_valid <= s_valid;
	end

	always_ff @(posedge clk) begin
		if (s_valid && s_ready) begin
			m_luma <= luma;
			m_user <= s_user;
			m_last <= s_last;
		end
	end

endmodule

//--- hw/luma_threshold.sv
module luma_threshold (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic [pix_pkg::luma_w-1:0] thresh,
	input  logic                       binarize,

	input  logic                       s_valid,
	input  logic [pix_pkg::luma_w-1:0] s_luma,
	input  logic                       s_user,
	input  logic                       s_last,
	output logic                       s_ready,

	output logic                       m_valid,
	output logic [pix_pkg::luma_w-1:0] m_luma,
	output logic                       m_user,
	output logic                       m_last,
	output logic                       m_hit,
	input  logic                       m_ready
);

	logic hit;

	assign hit     = s_luma >= thresh;
	assign s_ready = !m_valid || m_ready;

	always_ff @(posedge clk) begin
		if (!resetn)
			m_valid <= 1'b0;
		else if (s_ready)
			m_valid <= s_valid;
	end

	always_ff @(posedge clk) begin
		if (s_valid && s_ready) begin
			m_hit  <= hit;
			m_user <= s_user;
			m_last <= s_last;
			if (binarize)
				m_luma <= hit ? '1 : '0;	// full white or black.
			else
				m_luma <= s_luma;
		end
	end

endmodule

//--- hw/frame_stats.sv
module frame_stats (
	input  logic                       clk,
	input  logic                       resetn,

	// handshake into the output relay.
	input  logic                       valid,
	input  logic                       ready,
	input  logic                       user,
	input  logic                       hit,

	output logic [pix_pkg::stat_w-1:0] last_hits,
	output logic [pix_pkg::stat_w-1:0] frame_count
);

	logic [pix_pkg::stat_w-1:0] run_hits;
	logic                       fire;

	assign fire = valid && ready;

	// **********************************************************************
	// a tuser beat closes the running frame and opens the next one.
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (!resetn) begin
			run_hits    <= '0;
			last_hits   <= '0;
			frame_count <= '0;
		end else if (fire) begin
			if (user) begin
				last_hits   <= run_hits;
				frame_count <= frame_count + 1'b1;
				run_hits    <= pix_pkg::stat_w'(hit);	// the new frame starts here.
			end else begin
				run_hits <= run_hits + pix_pkg::stat_w'(hit);
			end
		end
	end

endmodule

//--- hw/wb_regs.sv
module wb_regs (
	input  logic                       clk,
	input  logic                       resetn,

	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [1:0]                 wb_adr,
	input  logic [31:0]                wb_dat_w,
	output logic [31:0]                wb_dat_r,
	output logic                       wb_ack,

	input  logic [pix_pkg::stat_w-1:0] last_hits,
	input  logic [pix_pkg::stat_w-1:0] frame_count,

	output logic                       fmt_yc,
	output logic                       binarize,
	output logic [pix_pkg::luma_w-1:0] thresh
);

	logic access;

	// a new request is one not yet acked.
	assign access = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wb_ack   <= 1'b0;
			fmt_yc   <= 1'b0;
			binarize <= 1'b0;
			thresh   <= 8'd128;
		end else begin
			wb_ack <= access;
			if (access && wb_we) begin
				case (wb_adr)
					pix_pkg::reg_ctrl: begin
						fmt_yc   <= wb_dat_w[0];
						binarize <= wb_dat_w[1];
					end
					pix_pkg::reg_thresh: thresh <= wb_dat_w[pix_pkg::luma_w-1:0];
					default: ;	// statistics are read only.
				endcase
			end
		end
	end

	// read data is latched with the ack so it is steady while ack is high.
	always_ff @(posedge clk) begin
		if (access) begin
			case (wb_adr)
				pix_pkg::reg_ctrl:   wb_dat_r <= {30'd0, binarize, fmt_yc};
				pix_pkg::reg_thresh: wb_dat_r <= 32'(thresh);
				pix_pkg::reg_hits:   wb_dat_r <= 32'(last_hits);
				default:             wb_dat_r <= 32'(frame_count);
			endcase
		end
	end

endmodule

//--- hw/luma_stream_top.sv
module luma_stream_top #(
	parameter int c_passthrough = 0
) (
	input  logic                       clk,
	input  logic                       resetn,

	input  logic                       s_axis_tvalid,
	input  logic [pix_pkg::pix_w-1:0]  s_axis_tdata,
	input  logic                       s_axis_tuser,
	input  logic                       s_axis_tlast,
	output logic                       s_axis_tready,

	output logic                       m_axis_tvalid,
	output logic [pix_pkg::luma_w-1:0] m_axis_tdata,
	output logic                       m_axis_tuser,
	output logic                       m_axis_tlast,
	input  logic                       m_axis_tready,

	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [1:0]                 wb_adr,
	input  logic [31:0]                wb_dat_w,
	output logic [31:0]                wb_dat_r,
	output logic                       wb_ack
);

	logic                       in_valid, in_user, in_last, in_ready;
	logic [pix_pkg::pix_w-1:0]  in_data;
	logic                       dec_valid, dec_user, dec_last, dec_ready;
	logic [pix_pkg::luma_w-1:0] dec_luma;
	logic                       thr_valid, thr_user, thr_last, thr_hit, thr_ready;
	logic [pix_pkg::luma_w-1:0] thr_luma;
	logic                       fmt_yc, binarize;
	logic [pix_pkg::luma_w-1:0] thresh;
	logic [pix_pkg::stat_w-1:0] last_hits, frame_count;

	// **********************************************************************
	// pixel path.
	// **********************************************************************
	axis_relay #(.c_pixel_width(pix_pkg::pix_w), .c_passthrough(c_passthrough)) relay_in (
		.clk, .resetn,
		.s_axis_tvalid, .s_axis_tdata, .s_axis_tuser, .s_axis_tlast, .s_axis_tready,
		.m_axis_tvalid(in_valid), .m_axis_tdata(in_data), .m_axis_tuser(in_user),
		.m_axis_tlast(in_last), .m_axis_tready(in_ready)
	);

	pixel_decode decode0 (
		.clk, .resetn, .fmt_yc,
		.s_valid(in_valid), .s_data(in_data), .s_user(in_user), .s_last(in_last),
		.s_ready(in_ready),
		.m_valid(dec_valid), .m_luma(dec_luma), .m_user(dec_user), .m_last(dec_last),
		.m_ready(dec_ready)
	);

	luma_threshold thresh0 (
		.clk, .resetn, .thresh, .binarize,
		.s_valid(dec_valid), .s_luma(dec_luma), .s_user(dec_user), .s_last(dec_last),
		.s_ready(dec_ready),
		.m_valid(thr_valid), .m_luma(thr_luma), .m_user(thr_user), .m_last(thr_last),
		.m_hit(thr_hit), .m_ready(thr_ready)
	);

	axis_relay #(.c_pixel_width(pix_pkg::luma_w), .c_passthrough(c_passthrough)) relay_out (
		.clk, .resetn,
		.s_axis_tvalid(thr_valid), .s_axis_tdata(thr_luma), .s_axis_tuser(thr_user),
		.s_axis_tlast(thr_last), .s_axis_tready(thr_ready),
		.m_axis_tvalid, .m_axis_tdata, .m_axis_tuser, .m_axis_tlast, .m_axis_tready
	);

	// **********************************************************************
	// statistics and register port.
	// **********************************************************************
	frame_stats stats0 (
		.clk, .resetn,
		.valid(thr_valid), .ready(thr_ready), .user(thr_user), .hit(thr_hit),
		.last_hits, .frame_count
	);

	wb_regs regs0 (
		.clk, .resetn,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.last_hits, .frame_count, .fmt_yc, .binarize, .thresh
	);

endmodule

//--- test/tb_luma_stream_sva.sv
module tb_luma_stream_sva (
	input logic       clk,
	input logic       resetn,
	input logic       s_axis_tready,
	input logic       m_axis_tvalid,
	input logic [7:0] m_axis_tdata,
	input logic       m_axis_tuser,
	input logic       m_axis_tlast,
	input logic       m_axis_tready,
	input logic       wb_cyc,
	input logic       wb_stb,
	input logic       wb_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;	// read by the testbench top.

	// **********************************************************************
	// stream rules on the output port.
	// **********************************************************************
	a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
			&& $stable(m_axis_tuser) && $stable(m_axis_tlast))
		else begin
			fail_count++;
			$error("output beat changed or dropped while the sink stalled");
		end

	// both valid and ready come out of reset low.
	a_reset_idle: assert property (@(posedge clk)
		$rose(resetn) |-> !m_axis_tvalid && !s_axis_tready)
		else begin
			fail_count++;
			$error("stream handshake not idle in the first cycle after reset");
		end

	// **********************************************************************
	// wishbone classic ack rules.
	// **********************************************************************
	a_ack_req: assert property (@(posedge clk) disable iff (!resetn)
		wb_ack |-> wb_cyc && wb_stb)
		else begin
			fail_count++;
			$error("wb_ack high without cyc and stb");
		end

	a_ack_pulse: assert property (@(posedge clk) disable iff (!resetn)
		wb_ack |=> !wb_ack)
		else begin
			fail_count++;
			$error("wb_ack high for two cycles in a row");
		end

endmodule

bind luma_stream_top tb_luma_stream_sva sva0 (
	.clk(clk),
	.resetn(resetn),
	.s_axis_tready(s_axis_tready),
	.m_axis_tvalid(m_axis_tvalid),
	.m_axis_tdata(m_axis_tdata),
	.m_axis_tuser(m_axis_tuser),
	.m_axis_tlast(m_axis_tlast),
	.m_axis_tready(m_axis_tready),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack)
);

//--- test/tb_luma_stream.sv
module tb_luma_stream;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int line_len         = 8;
	localparam int frame_len        = 3 * line_len;
	localparam int frames_per_phase = 2;
	localparam int phase_beats      = frames_per_phase * frame_len + 1;	// one beat opens the next frame.
	localparam int total_beats      = 2 * phase_beats;
	localparam int cycle_limit      = 20 * total_beats + 2000;

	logic                       clk = 1'b0;
	logic                       resetn;
	logic                       s_axis_tvalid;
	logic [pix_pkg::pix_w-1:0]  s_axis_tdata;
	logic                       s_axis_tuser;
	logic                       s_axis_tlast;
	logic                       s_axis_tready;
	logic                       m_axis_tvalid;
	logic [pix_pkg::luma_w-1:0] m_axis_tdata;
	logic                       m_axis_tuser;
	logic                       m_axis_tlast;
	logic                       m_axis_tready;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	logic [1:0]                 wb_adr;
	logic [31:0]                wb_dat_w;
	logic [31:0]                wb_dat_r;
	logic                       wb_ack;

	logic [31:0]                rng = 32'd83774;
	int                         cycles = 0;
	logic [9:0]                 expect_q[$];	// {user, last, luma} per beat.
	logic [pix_pkg::stat_w-1:0] run_hits_m = '0;
	logic [pix_pkg::stat_w-1:0] last_hits_m = '0;
	logic [pix_pkg::stat_w-1:0] frames_m = '0;

	luma_stream_top #(.c_passthrough(0)) dut0 (
		.clk, .resetn,
		.s_axis_tvalid, .s_axis_tdata, .s_axis_tuser, .s_axis_tlast, .s_axis_tready,
		.m_axis_tvalid, .m_axis_tdata, .m_axis_tuser, .m_axis_tlast, .m_axis_tready,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
	);

	always #20 clk = ~clk;

	// the run is bounded, and a failed assertion ends it right away.
	always @(negedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end else if (dut0.sva0.fail_count != 0) begin
			$display("a protocol assertion failed");
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// reference luma with the RGB565 fields scaled up to 8 bits.
	function automatic logic [7:0] model_luma(input logic [15:0] data, input logic yc);
		pix_pkg::pixel_word_t w;
		int                   r8;
		int                   g8;
		int                   b8;
		w = data;
		if (yc)
			return w.yc.y;
		r8 = (int'(w.rgb.r) << 3) | (int'(w.rgb.r) >> 2);
		g8 = (int'(w.rgb.g) << 2) | (int'(w.rgb.g) >> 4);
		b8 = (int'(w.rgb.b) << 3) | (int'(w.rgb.b) >> 2);
		return 8'((2 * r8 + 5 * g8 + b8) / 8);
	endfunction

	task automatic check_pixel(input logic [pix_pkg::luma_w-1:0] got_luma, exp_luma,
			input logic got_user, exp_user, input logic got_last, exp_last);
		if ({got_user, got_last, got_luma} !== {exp_user, exp_last, exp_luma}) begin
			$display("error: m_axis_tuser/tlast/tdata got %h/%h/%h expected %h/%h/%h",
				got_user, got_last, got_luma, exp_user, exp_last, exp_luma);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_stat(input string what, input logic [pix_pkg::stat_w-1:0] got,
			input logic [pix_pkg::stat_w-1:0] exp_val);
		if (got !== exp_val) begin
			$display("error: %s got %h expected %h", what, got, exp_val);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	// one classic cycle that starts and ends on a falling edge.
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		do
			@(negedge clk);
		while (!wb_ack);
		rdat = wb_dat_r;
		@(negedge clk);	// the request stays up through the edge that samples ack.
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic configure(input logic [1:0] ctrl, input logic [7:0] th);
		logic [31:0] rd;
		wb_access(1'b1, pix_pkg::reg_ctrl, 32'(ctrl), rd);
		wb_access(1'b1, pix_pkg::reg_thresh, 32'(th), rd);
		wb_access(1'b0, pix_pkg::reg_ctrl, 32'd0, rd);
		check_stat("wb_dat_r (ctrl)", rd[pix_pkg::stat_w-1:0], pix_pkg::stat_w'(ctrl));
		wb_access(1'b0, pix_pkg::reg_thresh, 32'd0, rd);
		check_stat("wb_dat_r (thresh)", rd[pix_pkg::stat_w-1:0], pix_pkg::stat_w'(th));
	endtask

	task automatic check_counters();
		logic [31:0] rd;
		wb_access(1'b0, pix_pkg::reg_hits, 32'd0, rd);
		check_stat("wb_dat_r (hits)", rd[pix_pkg::stat_w-1:0], last_hits_m);
		wb_access(1'b0, pix_pkg::reg_frames, 32'd0, rd);
		check_stat("wb_dat_r (frames)", rd[pix_pkg::stat_w-1:0], frames_m);
	endtask

	// no beat may follow the last expected one.
	task automatic confirm_drained();
		m_axis_tready = 1'b1;
		repeat (8) begin
			@(negedge clk);
			if (m_axis_tvalid) begin
				$display("an extra output beat appeared after the last expected one");
				$display("*** TEST FAILED ***");
				$fatal(1);
			end
		end
	endtask

	// **********************************************************************
	// stream one phase with random gaps and back-pressure.
	// **********************************************************************
	task automatic run_phase(input logic yc, input logic bin, input logic [7:0] th);
		int         sent;
		int         got;
		int         pos;
		logic       fired;
		logic       hit;
		logic [7:0] luma;
		logic [9:0] beat;
		sent  = 0;
		got   = 0;
		fired = 1'b0;
		while (got < phase_beats) begin
			@(negedge clk);
			rng = xorshift(rng);
			m_axis_tready = rng[1:0] != 2'b00;
			if (m_axis_tvalid && m_axis_tready) begin
				if (expect_q.size() == 0) begin
					$display("an output beat arrived while no beat was expected");
					$display("*** TEST FAILED ***");
					$fatal(1);
				end
				beat = expect_q.pop_front();
				check_pixel(m_axis_tdata, beat[7:0], m_axis_tuser, beat[9], m_axis_tlast, beat[8]);
				got++;
			end
			if (fired)
				s_axis_tvalid = 1'b0;	// last beat went in at the previous edge.
			if (!s_axis_tvalid && sent < phase_beats) begin
				rng = xorshift(rng);
				if (rng[2:0] != 3'd0) begin
					pos           = sent % frame_len;
					s_axis_tvalid = 1'b1;
					s_axis_tdata  = rng[31:16];
					s_axis_tuser  = pos == 0;
					s_axis_tlast  = (pos % line_len) == line_len - 1;
				end
			end
			fired = s_axis_tvalid && s_axis_tready;
			if (fired) begin
				luma = model_luma(s_axis_tdata, yc);
				hit  = luma >= th;
				beat = {s_axis_tuser, s_axis_tlast, bin ? (hit ? 8'hff : 8'h00) : luma};
				expect_q.push_back(beat);
				if (s_axis_tuser) begin
					last_hits_m = run_hits_m;
					frames_m    = frames_m + pix_pkg::stat_w'(1);
					run_hits_m  = pix_pkg::stat_w'(hit);
				end else begin
					run_hits_m = run_hits_m + pix_pkg::stat_w'(hit);
				end
				sent++;
			end
		end
		s_axis_tvalid = 1'b0;
	endtask

	initial begin
		logic [31:0] rd;
		logic [7:0]  th;
		resetn        = 1'b0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tuser  = 1'b0;
		s_axis_tlast  = 1'b0;
		m_axis_tready = 1'b1;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_dat_w      = '0;
		repeat (8) @(negedge clk);
		resetn = 1'b1;

		wb_access(1'b0, pix_pkg::reg_thresh, 32'd0, rd);
		check_stat("wb_dat_r (thresh)", rd[pix_pkg::stat_w-1:0], pix_pkg::stat_w'(128));
		check_counters();

		rng = xorshift(rng);
		th  = rng[7:0];
		configure(2'b00, th);	// RGB565, luma passed through.
		run_phase(1'b0, 1'b0, th);
		confirm_drained();
		check_counters();

		rng = xorshift(rng);
		th  = rng[7:0];
		configure(2'b11, th);	// yc, binarized.
		run_phase(1'b1, 1'b1, th);
		confirm_drained();
		check_counters();

		if (expect_q.size() == 0 && dut0.sva0.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("the model queue still holds beats or an assertion failed");
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

endmodule

//--- all.f
hw/pix_pkg.sv
hw/axis_relay.sv
hw/pixel_decode.sv
hw/luma_threshold.sv
hw/frame_stats.sv
hw/wb_regs.sv
hw/luma_stream_top.sv
test/tb_luma_stream_sva.sv
test/tb_luma_stream.sv

//--- run.sh
#!/usr/bin/env bash
# build the luma stream testbench with verilator, run it and scan the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_luma_stream -f all.f -o tb_luma_stream

./obj_dir/tb_luma_stream +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation finished without failures"
